/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= lcd_write_path.f
TOP        ?= lcd_write_path_tb
RTL_TOP    ?= lcd_write_path
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing -Wno-fatal
PASS_MSG   ?= TESTBENCH PASSED

RTL_FILES := $(shell grep '^verilog/' $(FILELIST))
ALL_FILES := $(shell grep '\.s\?v$$' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

$(SIM_BIN): $(FILELIST) $(ALL_FILES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* lcd_write_path.f */
verilog/video_pkg.sv
verilog/ppfifo_pkg.sv
verilog/tear_frame_writer.sv
verilog/ping_pong_fifo.sv
verilog/ppfifo_stream_reader.sv
verilog/lcd_write_path.sv
test/lcd_write_path_tb.sv

/* test/lcd_write_path_tb.sv */
// Directed tests for the tear-gated frame write path, DEPTH 8, TEAR_WINDOW 20
// Inputs change on the falling edge, outputs are sampled there too
// Expected beats are queued when the input side is seen ready
`timescale 1ns/1ps

module lcd_write_path_tb
  import video_pkg::*;
();

  localparam int DEPTH       = 8;
  localparam int TEAR_WINDOW = 20;
  localparam int TIMEOUT     = 300;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic       clk;
  logic       rst;
  logic       i_tear;
  logic       i_fsync;
  frame_cnt_t i_frame_pixels;
  pix_beat_t  i_pix;
  logic       i_pix_valid;
  logic       o_pix_ready;
  pix_beat_t  o_out;
  logic       o_out_valid;
  logic       i_out_ready;

  // Scoreboard and bookkeeping
  pix_beat_t   expected_q[$];
  logic [31:0] lfsr = 32'he056_0540;
  int          n_checks = 0;
  int          n_errors = 0;

  lcd_write_path #(
    .DEPTH       (DEPTH),
    .TEAR_WINDOW (TEAR_WINDOW)
  ) lcd_write_path_i (
    .clk            (clk),
    .rst            (rst),
    .i_tear         (i_tear),
    .i_fsync        (i_fsync),
    .i_frame_pixels (i_frame_pixels),
    .i_pix          (i_pix),
    .i_pix_valid    (i_pix_valid),
    .o_pix_ready    (o_pix_ready),
    .o_out          (o_out),
    .o_out_valid    (o_out_valid),
    .i_out_ready    (i_out_ready)
  );

  // 8 ns period
  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  task automatic check_beat(input pix_beat_t got, input pix_beat_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAILED at %0t: %s, got data %h last %b, expected data %h last %b",
               $time, what, got.data, got.last, exp.data, exp.last);
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Tear low long enough to be seen, then a rising edge and a late or timely fsync
  task automatic tear_edge();
    @(negedge clk);
    i_tear = 1'b0;
    repeat (2) @(negedge clk);
    i_tear = 1'b1;
  endtask

  task automatic pulse_fsync();
    @(negedge clk);
    i_fsync = 1'b1;
    @(negedge clk);
    i_fsync = 1'b0;
  endtask

  task automatic start_frame(input int fsync_delay);
    tear_edge();
    repeat (fsync_delay) @(negedge clk);
    pulse_fsync();
  endtask

  // Offer data that must not be taken, nothing may come out either
  task automatic offer_idle(input int cycles, input string what);
    pix_beat_t beat;
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      beat.data   = PIX_W'(rand_bits(PIX_W));
      beat.last   = 1'b0;
      i_pix       = beat;
      i_pix_valid = 1'b1;
      check_level(o_pix_ready, 1'b0, what);
      check_level(o_out_valid, 1'b0, what);
    end
    @(negedge clk);
    i_pix_valid = 1'b0;
  endtask

  // One packet, last on the final beat, each beat held until taken
  task automatic send_packet(input int n);
    pix_beat_t beat;
    logic      accepted;
    int        wait_cnt;
    for (int i = 0; i < n; i++) begin
      beat.data = PIX_W'(rand_bits(PIX_W));
      beat.last = (i == n - 1);
      accepted  = 1'b0;
      wait_cnt  = 0;
      while (!accepted && (wait_cnt < TIMEOUT)) begin
        @(negedge clk);
        i_pix       = beat;
        i_pix_valid = 1'b1;
        // Ready only depends on registered state, so it holds until the edge
        if (o_pix_ready) begin
          accepted = 1'b1;
          expected_q.push_back(beat);
        end
        wait_cnt++;
      end
      if (!accepted) begin
        n_errors++;
        $display("Timeout after %0d cycles waiting for o_pix_ready on beat %0d", TIMEOUT, i);
        break;
      end
    end
    @(negedge clk);
    i_pix_valid = 1'b0;
  endtask

  // Take n output beats, optionally with random back-pressure
  task automatic drain_beats(input int n, input logic stall);
    int got;
    int idle;
    got  = 0;
    idle = 0;
    while ((got < n) && (idle < TIMEOUT)) begin
      @(negedge clk);
      i_out_ready = stall ? (rand_bits(2) != 0) : 1'b1;
      if (o_out_valid && i_out_ready) begin
        if (expected_q.size() == 0) begin
          n_errors++;
          $display("Output beat %h came out with nothing expected", o_out.data);
        end else begin
          check_beat(o_out, expected_q.pop_front(), "output beat");
        end
        got++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (got < n) begin
      n_errors++;
      $display("Timeout waiting for output beats, %0d of %0d received", got, n);
    end
    @(negedge clk);
    i_out_ready = 1'b1;
    check_level(o_out_valid, 1'b0, "no extra beat after the frame");
  endtask

  task automatic test_idle_after_reset();
    check_level(o_pix_ready, 1'b0, "o_pix_ready after reset");
    check_level(o_out_valid, 1'b0, "o_out_valid after reset");
    offer_idle(12, "idle with tear low");
  endtask

  task automatic test_short_frame();
    i_frame_pixels = 6;
    start_frame(3);
    fork
      send_packet(6);
      drain_beats(6, 1'b0);
    join
  endtask

  // 20 pixels over 8-word buffers, output stalled at random
  task automatic test_multi_buffer_frame();
    i_frame_pixels = 20;
    start_frame(4);
    fork
      send_packet(20);
      drain_beats(20, 1'b1);
    join
  endtask

  // fsync well past the window must not open the gate
  task automatic test_missed_window();
    i_frame_pixels = 6;
    tear_edge();
    offer_idle(2 * TEAR_WINDOW + 5, "ready before a late fsync");
    pulse_fsync();
    offer_idle(10, "ready after a late fsync");
    start_frame(2);
    fork
      send_packet(6);
      drain_beats(6, 1'b0);
    join
  endtask

  // Gate stays shut until tear falls and rises again
  task automatic test_tear_held_high();
    i_frame_pixels = 4;
    start_frame(2);
    fork
      send_packet(4);
      drain_beats(4, 1'b0);
    join
    pulse_fsync();
    offer_idle(15, "ready with tear held high after a frame");
    i_frame_pixels = 5;
    start_frame(2);
    fork
      send_packet(5);
      drain_beats(5, 1'b0);
    join
    @(negedge clk);
    i_tear = 1'b0;
  endtask

  initial begin
    rst            = 1'b1;
    i_tear         = 1'b0;
    i_fsync        = 1'b0;
    i_frame_pixels = '0;
    i_pix          = '0;
    i_pix_valid    = 1'b0;
    i_out_ready    = 1'b1;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    test_idle_after_reset();
    test_short_frame();
    test_multi_buffer_frame();
    test_missed_window();
    test_tear_held_high();
    check_level(expected_q.size() == 0, 1'b1, "scoreboard empty at the end");

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : lcd_write_path_tb

/* verilog/lcd_write_path.sv */
// Frame write path: tear-gated writer, ping-pong FIFO, stream reader
// Single clock throughout, frame size is a static input
// Input to output latency depends on buffer fill and back-pressure
`timescale 1ns/1ps

module lcd_write_path
  import video_pkg::*;
  import ppfifo_pkg::*;
#(
  parameter int DEPTH       = 64,
  parameter int TEAR_WINDOW = 100
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       i_tear,
  input  logic       i_fsync,
  input  frame_cnt_t i_frame_pixels,
  input  pix_beat_t  i_pix,
  input  logic       i_pix_valid,
  output logic       o_pix_ready,
  output pix_beat_t  o_out,
  output logic       o_out_valid,
  input  logic       i_out_ready
);

  // Write side
  pp_sel_t   wr_rdy;
  pp_sel_t   wr_act;
  pp_cnt_t   wr_size;
  pp_wr_t    wr;
  // Read side
  logic      rd_rdy;
  logic      rd_act;
  pp_cnt_t   rd_size;
  logic      rd_stb;
  pix_beat_t rd_beat;

  tear_frame_writer #(
    .TEAR_WINDOW (TEAR_WINDOW)
  ) u_writer (
    .clk            (clk),
    .rst            (rst),
    .i_tear         (i_tear),
    .i_fsync        (i_fsync),
    .i_frame_pixels (i_frame_pixels),
    .i_pix          (i_pix),
    .i_pix_valid    (i_pix_valid),
    .o_pix_ready    (o_pix_ready),
    .i_pp_rdy       (wr_rdy),
    .i_pp_size      (wr_size),
    .o_pp_act       (wr_act),
    .o_pp_wr        (wr)
  );

  ping_pong_fifo #(
    .DEPTH (DEPTH)
  ) u_fifo (
    .clk       (clk),
    .rst       (rst),
    .o_wr_rdy  (wr_rdy),
    .i_wr_act  (wr_act),
    .o_wr_size (wr_size),
    .i_wr      (wr),
    .o_rd_rdy  (rd_rdy),
    .i_rd_act  (rd_act),
    .o_rd_size (rd_size),
    .i_rd_stb  (rd_stb),
    .o_rd_beat (rd_beat)
  );

  ppfifo_stream_reader u_reader (
    .clk         (clk),
    .rst         (rst),
    .i_rd_rdy    (rd_rdy),
    .o_rd_act    (rd_act),
    .i_rd_size   (rd_size),
    .o_rd_stb    (rd_stb),
    .i_rd_beat   (rd_beat),
    .o_out       (o_out),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready)
  );

endmodule : lcd_write_path

/* verilog/ping_pong_fifo.sv */
// Two buffers of DEPTH words, single clock, DEPTH of at least 2
// Only one write buffer and one read buffer may be held at a time
// Committed buffers are handed to the reader in commit order
`timescale 1ns/1ps

module ping_pong_fifo
  import video_pkg::*;
  import ppfifo_pkg::*;
#(
  parameter int DEPTH = 64
) (
  input  logic      clk,
  input  logic      rst,
  // Write side
  output pp_sel_t   o_wr_rdy,
  input  pp_sel_t   i_wr_act,
  output pp_cnt_t   o_wr_size,
  input  pp_wr_t    i_wr,
  // Read side
  output logic      o_rd_rdy,
  input  logic      i_rd_act,
  output pp_cnt_t   o_rd_size,
  input  logic      i_rd_stb,
  output pix_beat_t o_rd_beat
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef enum logic [1:0] {
    BUF_FREE,
    BUF_WRITING,
    BUF_COMMITTED,
    BUF_READING
  } buf_state_t;

  pix_beat_t  r_mem [2][DEPTH];
  buf_state_t r_state [2];
  pp_cnt_t    r_cnt [2];
  logic       r_oldest;
  pp_cnt_t    r_wr_ptr;
  pp_cnt_t    r_rd_ptr;

  logic w_wr_sel;
  logic w_wr_start;
  logic w_reading;
  logic w_rd_sel;
  logic w_claim;
  logic w_release;

  // Writer holds at most one act bit
  assign w_wr_sel   = i_wr_act[1];
  assign w_wr_start = (i_wr_act[0] && (r_state[0] == BUF_FREE)) ||
                      (i_wr_act[1] && (r_state[1] == BUF_FREE));

  assign w_reading = (r_state[0] == BUF_READING) || (r_state[1] == BUF_READING);
  assign w_claim   = i_rd_act && !w_reading && (r_state[r_oldest] == BUF_COMMITTED);
  assign w_release = w_reading && !i_rd_act;

  // Before the claim lands, read from the oldest committed buffer
  // so word 0 is already on o_rd_beat
  assign w_rd_sel = (r_state[1] == BUF_READING) ? 1'b1 :
                    (r_state[0] == BUF_READING) ? 1'b0 : r_oldest;

  assign o_wr_rdy[0] = (r_state[0] == BUF_FREE);
  assign o_wr_rdy[1] = (r_state[1] == BUF_FREE);
  assign o_wr_size   = pp_cnt_t'(DEPTH);
  assign o_rd_rdy    = (r_state[r_oldest] == BUF_COMMITTED);
  assign o_rd_size   = r_cnt[r_oldest];
  assign o_rd_beat   = r_mem[w_rd_sel][r_rd_ptr[AW-1:0]];

  // Storage
  always_ff @(posedge clk) begin
    if (i_wr.stb && (i_wr_act != '0)) begin
      r_mem[w_wr_sel][r_wr_ptr[AW-1:0]] <= i_wr.beat;
    end
  end

  // Buffer ownership
  always_ff @(posedge clk) begin
    if (rst) begin
      r_state[0] <= BUF_FREE;
      r_state[1] <= BUF_FREE;
      r_cnt[0]   <= '0;
      r_cnt[1]   <= '0;
      r_oldest   <= 1'b0;
    end else begin
      for (int b = 0; b < 2; b++) begin
        case (r_state[b])
          BUF_FREE: begin
            if (i_wr_act[b]) begin
              r_state[b] <= BUF_WRITING;
            end
          end
          BUF_WRITING: begin
            // act dropped, commit with the words written so far
            if (!i_wr_act[b]) begin
              r_state[b] <= BUF_COMMITTED;
              r_cnt[b]   <= r_wr_ptr;
              if (r_state[1-b] != BUF_COMMITTED) begin
                r_oldest <= (b == 1);
              end
            end
          end
          BUF_COMMITTED: begin
            if (w_claim && (r_oldest == (b == 1))) begin
              r_state[b] <= BUF_READING;
            end
          end
          default: begin
            if (!i_rd_act) begin
              r_state[b] <= BUF_FREE;
            end
          end
        endcase
      end
      // Other buffer is next in line once this one is taken
      if (w_claim) begin
        r_oldest <= !r_oldest;
      end
    end
  end

  // Word pointers
  always_ff @(posedge clk) begin
    if (rst) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
    end else begin
      if (w_wr_start) begin
        r_wr_ptr <= '0;
      end else if (i_wr.stb) begin
        r_wr_ptr <= r_wr_ptr + 1'b1;
      end
      // Stb may arrive on the claim edge itself
      if (w_release) begin
        r_rd_ptr <= '0;
      end else if (i_rd_stb) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
    end
  end

endmodule : ping_pong_fifo

/* verilog/ppfifo_pkg.sv */
// Ping-pong FIFO exchange types
// Two buffers only, so every select vector is 2 bits wide
// Counts are limited to 24 bits

package ppfifo_pkg;

  import video_pkg::*;

  // One bit per buffer, used for rdy and act vectors
  typedef logic [1:0] pp_sel_t;

  // Fill count or buffer size in words
  typedef logic [23:0] pp_cnt_t;

  // Write strobe plus the beat it carries
  // Only meaningful while the writer holds an act bit
  typedef struct packed {
    logic      stb;
    pix_beat_t beat;
  } pp_wr_t;

endpackage : ppfifo_pkg

/* verilog/ppfifo_stream_reader.sv */
// Drains committed ping-pong buffers to a valid/ready pixel stream
// Output beat is registered and held while i_out_ready is low
// rd_stb is combinational and fires on every word loaded
`timescale 1ns/1ps

module ppfifo_stream_reader
  import video_pkg::*;
  import ppfifo_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      i_rd_rdy,
  output logic      o_rd_act,
  input  pp_cnt_t   i_rd_size,
  output logic      o_rd_stb,
  input  pix_beat_t i_rd_beat,
  output pix_beat_t o_out,
  output logic      o_out_valid,
  input  logic      i_out_ready
);

  logic      r_act;
  pp_cnt_t   r_size;
  pp_cnt_t   r_cnt;
  logic      r_valid;
  pix_beat_t r_out;
  logic      w_load;
  logic      w_done;

  // Load when words remain and the output slot is empty or taken
  assign w_load = r_act && (r_cnt < r_size) && (!r_valid || i_out_ready);

  // Release on the edge that loads the final word
  assign w_done = (r_cnt == r_size) ||
                  (w_load && ((r_cnt + pp_cnt_t'(1)) == r_size));

  assign o_rd_act    = r_act;
  assign o_rd_stb    = w_load;
  assign o_out       = r_out;
  assign o_out_valid = r_valid;

  always_ff @(posedge clk) begin
    if (w_load) begin
      r_out <= i_rd_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      r_act   <= 1'b0;
      r_size  <= '0;
      r_cnt   <= '0;
      r_valid <= 1'b0;
    end else begin
      if (w_load) begin
        r_valid <= 1'b1;
        r_cnt   <= r_cnt + 1'b1;
      end else if (i_out_ready) begin
        r_valid <= 1'b0;
      end

      if (!r_act) begin
        // Claim and latch size of the oldest buffer
        if (i_rd_rdy) begin
          r_act  <= 1'b1;
          r_size <= i_rd_size;
          r_cnt  <= '0;
        end
      end else if (w_done) begin
        r_act <= 1'b0;
      end
    end
  end

endmodule : ppfifo_stream_reader

/* verilog/tear_frame_writer.sv */
// Frames are accepted only after a tear rising edge and a timely fsync
// fsync must come within TEAR_WINDOW cycles of the edge
// A tear edge seen outside the idle state is ignored
// Frame ends on a packet end once i_frame_pixels beats have passed
`timescale 1ns/1ps

module tear_frame_writer
  import video_pkg::*;
  import ppfifo_pkg::*;
#(
  parameter int TEAR_WINDOW = 100
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       i_tear,
  input  logic       i_fsync,
  input  frame_cnt_t i_frame_pixels,
  input  pix_beat_t  i_pix,
  input  logic       i_pix_valid,
  output logic       o_pix_ready,
  input  pp_sel_t    i_pp_rdy,
  input  pp_cnt_t    i_pp_size,
  output pp_sel_t    o_pp_act,
  output pp_wr_t     o_pp_wr
);

  localparam int WIN_W = $clog2(TEAR_WINDOW + 1);

  typedef enum logic [1:0] {
    ST_WAIT_TEAR,
    ST_WAIT_FRAME,
    ST_READ_FRAME,
    ST_WAIT_END_TEAR
  } gate_state_t;

  gate_state_t      r_state;
  pp_sel_t          r_act;
  pp_cnt_t          r_count;
  logic             r_last;
  frame_cnt_t       r_pix_cnt;
  logic [WIN_W-1:0] r_win_cnt;
  logic             r_tear_d;
  logic             r_wr_stb;
  pix_beat_t        r_wr_beat;
  logic             w_tear_rise;
  logic             w_accept;

  assign w_tear_rise = i_tear && !r_tear_d;

  // Ready only with an owned buffer that still has room
  // and no last beat waiting to close it
  assign o_pix_ready = (r_act != '0) &&
                       (r_count < i_pp_size) &&
                       !r_last &&
                       (r_state == ST_READ_FRAME);

  assign w_accept = i_pix_valid && o_pix_ready;

  assign o_pp_act = r_act;
  assign o_pp_wr  = '{stb: r_wr_stb, beat: r_wr_beat};

  // Beat payload, captured on the accepting edge
  always_ff @(posedge clk) begin
    if (w_accept) begin
      r_wr_beat <= i_pix;
    end
  end

  always_ff @(posedge clk) begin
    // Strobe and last pulse for one cycle only
    r_wr_stb <= 1'b0;
    r_last   <= 1'b0;
    if (rst) begin
      r_state   <= ST_WAIT_TEAR;
      r_act     <= '0;
      r_count   <= '0;
      r_pix_cnt <= '0;
      r_win_cnt <= '0;
      r_tear_d  <= 1'b0;
    end else begin
      r_tear_d <= i_tear;

      // Grab a free buffer whenever none is held, bit 0 first
      if ((r_act == '0) && (i_pp_rdy != '0)) begin
        r_count <= '0;
        if (i_pp_rdy[0]) begin
          r_act <= pp_sel_t'(2'b01);
        end else begin
          r_act <= pp_sel_t'(2'b10);
        end
      end

      case (r_state)
        ST_WAIT_TEAR: begin
          if (w_tear_rise) begin
            r_win_cnt <= '0;
            r_state   <= ST_WAIT_FRAME;
          end
        end

        ST_WAIT_FRAME: begin
          if (i_fsync) begin
            r_pix_cnt <= '0;
            r_state   <= ST_READ_FRAME;
          end else if (r_win_cnt < WIN_W'(TEAR_WINDOW)) begin
            r_win_cnt <= r_win_cnt + 1'b1;
          end else begin
            // Window missed, wait for the next tear edge
            r_state <= ST_WAIT_TEAR;
          end
        end

        ST_READ_FRAME: begin
          if (r_act != '0) begin
            if (r_last) begin
              // Packet ended, commit buffer
              r_act <= '0;
              if (r_pix_cnt >= i_frame_pixels) begin
                r_state <= ST_WAIT_END_TEAR;
              end
            end else if (r_count >= i_pp_size) begin
              // Buffer full, commit and grab the other one
              r_act <= '0;
            end else if (w_accept) begin
              r_wr_stb  <= 1'b1;
              r_last    <= i_pix.last;
              r_count   <= r_count + 1'b1;
              r_pix_cnt <= r_pix_cnt + 1'b1;
            end
          end
        end

        ST_WAIT_END_TEAR: begin
          // Hold off until the panel drops tear
          if (!i_tear) begin
            r_state <= ST_WAIT_TEAR;
          end
        end

        default: begin
          r_state <= ST_WAIT_TEAR;
        end
      endcase
    end
  end

endmodule : tear_frame_writer

/* verilog/video_pkg.sv */
// Display stream types shared by writer, FIFO and reader
// Pixel is a single packed word, no byte keep
// One beat per clock at most, last marks end of a packet

package video_pkg;

  // Width of one pixel word (RGB888)
  localparam int PIX_W = 24;

  // One stream beat as carried through the write path
  // Last sits in the MSB, just above the pixel data
  typedef struct packed {
    logic             last;
    logic [PIX_W-1:0] data;
  } pix_beat_t;

  // Pixel count for a whole frame
  // Compared against the number of accepted beats
  typedef logic [31:0] frame_cnt_t;

endpackage : video_pkg
